// ==== verification/decode_testdata.mem ====
// wid pc instr | ex_type op_type op_mod wb rd rs1 rs2 imm use_pc use_imm event
// event: 0 none, 1 release, 2 join
0 00001000 ffb10093 1 0 0 1 01 02 00 fffffffb 0 1 1
1 00001004 40725193 1 7 0 1 03 04 00 00000007 0 1 1
2 00001008 01f31293 1 2 0 1 05 06 00 0000001f 0 1 1
3 0000100c 409403b3 1 1 0 1 07 08 09 00000000 0 0 1
0 00001010 40c5d533 1 7 0 1 0a 0b 0c 00000000 0 0 1
1 00001014 00f776b3 1 9 0 1 0d 0e 0f 00000000 0 0 1
2 00001018 00108013 1 0 0 0 00 01 00 00000001 0 1 1
3 0000101c 123452b7 1 a 0 1 05 00 00 12345000 0 1 1
0 00001020 fffff317 1 b 0 1 06 00 00 fffff000 1 1 1
1 00001024 ff9ff0ef 1 8 1 1 01 00 00 fffffff8 1 1 0
2 00001028 00008067 1 9 1 0 00 01 00 00000000 0 1 0
3 0000102c 00311863 1 1 1 0 00 02 03 00000010 1 1 0
0 00001030 fe527ee3 1 7 1 0 00 04 05 fffffffc 1 1 0
1 00001034 ffc4a403 2 2 0 1 08 09 00 fffffffc 0 0 1
2 00001038 00a5a423 2 a 0 0 00 0b 0a 00000008 0 0 1
3 0000103c 0ff0000f 2 0 1 0 00 00 00 00000000 0 0 1
0 00001040 0002800b 3 0 0 0 00 05 00 00000000 0 0 0
1 00001044 0013000b 3 5 0 0 00 06 00 00000000 0 0 0
2 00001048 0083900b 3 1 0 0 00 07 08 00000000 0 0 1
3 0000104c 0004a00b 3 2 0 0 00 09 00 00000000 0 0 0
0 00001050 0001b00b 3 3 0 0 00 00 00 00000000 0 0 2
1 00001054 00b5400b 3 4 0 0 00 0a 0b 00000000 0 0 0
2 00001058 1234567f 0 0 0 0 00 00 00 00000000 0 0 1

// ==== sim.f ====
hdl/core_cfg_pkg.sv
hdl/isa_pkg.sv
hdl/instr_decoder.sv
hdl/stream_fifo.sv
hdl/decode_stage.sv
verification/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - files:
      - hdl/core_cfg_pkg.sv
      - hdl/isa_pkg.sv
      - hdl/instr_decoder.sv
      - hdl/stream_fifo.sv
      - hdl/decode_stage.sv
  - target: simulation
    files:
      - verification/decode_stage_tb.sv

// ==== verification/decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb;
    import core_cfg_pkg::*;
    import isa_pkg::*;

    localparam int max_entries = 64;
    localparam int ncols       = 14;  // Words per data-file line
    localparam int wait_limit  = 200;
    localparam int run_limit   = wait_limit * (max_entries + 2);

    logic        clk;
    logic        rst_n;
    fetch_t      fetch;
    logic        fetch_valid;
    logic        fetch_ready;
    decoded_t    dec;
    logic        dec_valid;
    logic        dec_ready;
    warp_event_t evt;
    logic        evt_valid;
    logic        evt_ready;

    logic [31:0] tdata [max_entries*ncols];
    int          evt_list [$];  // Entry index of each expected event
    int          n_entries;
    int          n_checks;
    int          n_errors;
    int          n_timeouts;
    integer      seed;
    bit          abort;
    bit          dec_done;
    bit          evt_done;

    decode_stage u_decode_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch       (fetch),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .dec         (dec),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .evt         (evt),
        .evt_valid   (evt_valid),
        .evt_ready   (evt_ready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] field(input int idx, input int col);
        return tdata[idx*ncols + col];
    endfunction

    function automatic logic [num_threads-1:0] tmask_for(input int idx);
        return num_threads'(idx * 5 + 3);
    endfunction

    task automatic compare_val(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_decoded(input int idx);
        int errs_before;
        errs_before = n_errors;
        compare_val("dec.uuid", idx & 'hff, dec.uuid);  // Also proves fetch order
        compare_val("dec.wid", field(idx, 0), dec.wid);
        compare_val("dec.tmask", tmask_for(idx), dec.tmask);
        compare_val("dec.pc", field(idx, 1), dec.pc);
        compare_val("dec.ex_type", field(idx, 3), dec.ex_type);
        compare_val("dec.op_type", field(idx, 4), dec.op_type);
        compare_val("dec.op_mod", field(idx, 5), dec.op_mod);
        compare_val("dec.wb", field(idx, 6), dec.wb);
        compare_val("dec.rd", field(idx, 7), dec.rd);
        compare_val("dec.rs1", field(idx, 8), dec.rs1);
        compare_val("dec.rs2", field(idx, 9), dec.rs2);
        compare_val("dec.imm", field(idx, 10), dec.imm);
        compare_val("dec.use_pc", field(idx, 11), dec.use_pc);
        compare_val("dec.use_imm", field(idx, 12), dec.use_imm);
        $display("test %0d: instr %h %s", idx, field(idx, 2),
                 (n_errors == errs_before) ? "ok" : "mismatch");
    endtask

    task automatic drive_fetches();
        int idx;
        int cycles;
        bit taken;
        for (idx = 0; idx < n_entries && !abort; idx++) begin
            @(negedge clk);
            fetch.uuid  = uuid_bits'(idx);
            fetch.wid   = wid_bits'(field(idx, 0));
            fetch.tmask = tmask_for(idx);
            fetch.pc    = field(idx, 1);
            fetch.instr = field(idx, 2);
            fetch_valid = 1'b1;
            taken  = 1'b0;
            cycles = 0;
            while (!taken && !abort) begin
                @(posedge clk);
                if (fetch_ready) begin
                    taken = 1'b1;
                end else begin
                    cycles = cycles + 1;
                    if (cycles >= wait_limit) begin
                        $display("timeout: fetch %0d was not accepted within %0d cycles",
                                 idx, wait_limit);
                        n_timeouts++;
                        abort = 1'b1;
                    end
                end
            end
        end
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    task automatic watch_decoded();
        int idx;
        int cycles;
        idx    = 0;
        cycles = 0;
        while (idx < n_entries && !abort) begin
            @(posedge clk);
            if (dec_valid && dec_ready) begin
                check_decoded(idx);
                idx++;
                cycles = 0;
            end else begin
                cycles = cycles + 1;
                if (cycles >= wait_limit) begin
                    $display("timeout: decoded entry %0d did not appear within %0d cycles",
                             idx, wait_limit);
                    n_timeouts++;
                    abort = 1'b1;
                end
            end
        end
        dec_done = 1'b1;
    endtask

    task automatic watch_events();
        int k;
        int e;
        int cycles;
        k      = 0;
        cycles = 0;
        while (k < evt_list.size() && !abort) begin
            @(posedge clk);
            if (evt_valid && evt_ready) begin
                e = evt_list[k];
                compare_val("evt.wid", field(e, 0), evt.wid);
                compare_val("evt.is_join", field(e, 13) == 2, evt.is_join);
                compare_val("evt.is_release", field(e, 13) == 1, evt.is_release);
                k++;
                cycles = 0;
            end else begin
                cycles = cycles + 1;
                if (cycles >= wait_limit) begin
                    $display("timeout: no warp event for entry %0d within %0d cycles",
                             evt_list[k], wait_limit);
                    n_timeouts++;
                    abort = 1'b1;
                end
            end
        end
        $display("test events: %0d of %0d warp events checked", k, evt_list.size());
        evt_done = 1'b1;
    endtask

    // Random back-pressure on both outputs, about 70% ready
    task automatic drive_ready();
        int cycles;
        bit dec_go;
        bit evt_go;
        cycles = 0;
        while (!(dec_done && evt_done) && !abort && cycles < run_limit) begin
            @(negedge clk);
            dec_go    = ($unsigned($random(seed)) % 100) < 70;
            evt_go    = ($unsigned($random(seed)) % 100) < 70;
            dec_ready = dec_go && !dec_done;  // No popping once all are checked
            evt_ready = evt_go && !evt_done;
            cycles = cycles + 1;
        end
        if (cycles >= run_limit) begin
            $display("timeout: the run did not finish within %0d cycles", run_limit);
            n_timeouts++;
            abort = 1'b1;
        end
    endtask

    initial begin
        int a;
        int drain_errs;
        clk         = 1'b0;
        rst_n       = 1'b0;
        fetch       = '0;
        fetch_valid = 1'b0;
        dec_ready   = 1'b0;
        evt_ready   = 1'b0;
        seed        = 88;
        n_checks    = 0;
        n_errors    = 0;
        n_timeouts  = 0;
        abort       = 1'b0;
        dec_done    = 1'b0;
        evt_done    = 1'b0;

        // Unwritten words hold a wid far out of range, which ends the table
        for (a = 0; a < max_entries*ncols; a++)
            tdata[a] = 32'hdead_0000 | a;
        $readmemh("verification/decode_testdata.mem", tdata);
        n_entries = 0;
        while (n_entries < max_entries && field(n_entries, 0) < num_warps)
            n_entries++;
        for (a = 0; a < n_entries; a++) begin
            if (field(a, 13) != 0)
                evt_list.push_back(a);
        end
        if (n_entries == 0) begin
            $display("the data file holds no test entries");
            n_errors++;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare_val("dec_valid", 0, dec_valid);
        compare_val("evt_valid", 0, evt_valid);
        compare_val("fetch_ready", 1, fetch_ready);
        $display("test reset: %s", (n_errors == 0) ? "ok" : "mismatch");

        fork
            drive_fetches();
            watch_decoded();
            watch_events();
            drive_ready();
        join

        if (!abort) begin
            // Readies stay low here and a leftover item would still show as valid
            drain_errs = n_errors;
            repeat (4) @(negedge clk);
            compare_val("dec_valid", 0, dec_valid);
            compare_val("evt_valid", 0, evt_valid);
            $display("test drain: %0d entries, %s", n_entries,
                     (n_errors == drain_errs) ? "ok" : "mismatch");
        end

        $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  core_cfg_pkg::fetch_t      fetch,
    input  logic                      fetch_valid,
    output logic                      fetch_ready,
    output isa_pkg::decoded_t         dec,
    output logic                      dec_valid,
    input  logic                      dec_ready,
    output core_cfg_pkg::warp_event_t evt,
    output logic                      evt_valid,
    input  logic                      evt_ready
);
    import core_cfg_pkg::*;
    import isa_pkg::*;

    decoded_t    dec_next;
    warp_event_t evt_next;
    logic        evt_needed;
    logic        dec_in_ready;
    logic        evt_in_ready;
    logic        fetch_fire;

    instr_decoder u_decoder (
        .fetch      (fetch),
        .dec        (dec_next),
        .evt        (evt_next),
        .evt_needed (evt_needed)
    );

    // Event queue only matters when this instruction makes an event
    assign fetch_ready = dec_in_ready && (!evt_needed || evt_in_ready);
    assign fetch_fire  = fetch_valid && fetch_ready;

    stream_fifo #(.payload_t(decoded_t), .depth(2)) u_dec_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (dec_next),
        .in_valid  (fetch_fire),
        .in_ready  (dec_in_ready),
        .out_data  (dec),
        .out_valid (dec_valid),
        .out_ready (dec_ready)
    );

    stream_fifo #(.payload_t(warp_event_t), .depth(2)) u_evt_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (evt_next),
        .in_valid  (fetch_fire && evt_needed),
        .in_ready  (evt_in_ready),
        .out_data  (evt),
        .out_valid (evt_valid),
        .out_ready (evt_ready)
    );

endmodule

// ==== hdl/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);
    localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_bits = $clog2(depth + 1);

    payload_t            mem [depth];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [cnt_bits-1:0] count;
    logic                push;
    logic                pop;

    // Wraps for depths that are not a power of two
    function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
        logic [ptr_bits-1:0] nxt;
        if (ptr == ptr_bits'(depth - 1))
            nxt = '0;
        else
            nxt = ptr + 1'b1;
        return nxt;
    endfunction

    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign in_ready  = (count != cnt_bits'(depth)) || out_ready;  // Full but draining

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  core_cfg_pkg::fetch_t      fetch,
    output isa_pkg::decoded_t         dec,
    output core_cfg_pkg::warp_event_t evt,
    output logic                      evt_needed
);
    import core_cfg_pkg::*;
    import isa_pkg::*;

    logic [31:0]        instr;
    logic [6:0]         opcode;
    logic [2:0]         func3;
    logic [6:0]         func7;
    logic [nr_bits-1:0] rd;
    logic [nr_bits-1:0] rs1;
    logic [nr_bits-1:0] rs2;

    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] shamt_imm;
    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] j_imm;

    ex_type_e               ex_type;
    op_type_e               op_type;
    logic [op_mod_bits-1:0] op_mod;
    logic [nr_bits-1:0]     rd_r;
    logic [nr_bits-1:0]     rs1_r;
    logic [nr_bits-1:0]     rs2_r;
    logic [xlen-1:0]        imm;
    logic                   use_rd;
    logic                   use_pc;
    logic                   use_imm;
    logic                   is_join;
    logic                   is_wstall;

    // Shared by OP-IMM and OP; sub exists only in the register form
    function automatic op_type_e alu_op(input logic [2:0] f3, input logic alt,
                                        input logic allow_sub);
        op_type_e op;
        case (f3)
            3'h0:    op = (alt && allow_sub) ? alu_sub : alu_add;
            3'h1:    op = alu_sll;
            3'h2:    op = alu_slt;
            3'h3:    op = alu_sltu;
            3'h4:    op = alu_xor;
            3'h5:    op = alt ? alu_sra : alu_srl;
            3'h6:    op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign instr  = fetch.instr;
    assign opcode = instr[6:0];
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign i_imm     = {{(xlen-12){instr[31]}}, instr[31:20]};
    assign shamt_imm = {{(xlen-5){1'b0}}, instr[24:20]};
    assign s_imm     = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm     = {{(xlen-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                        instr[11:8], 1'b0};
    assign u_imm     = {{(xlen-32){instr[31]}}, instr[31:12], 12'b0};
    assign j_imm     = {{(xlen-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                        instr[30:21], 1'b0};

    always_comb begin
        ex_type   = ex_none;
        op_type   = '0;
        op_mod    = '0;
        rd_r      = '0;
        rs1_r     = '0;
        rs2_r     = '0;
        imm       = '0;
        use_rd    = 1'b0;
        use_pc    = 1'b0;
        use_imm   = 1'b0;
        is_join   = 1'b0;
        is_wstall = 1'b0;

        case (opcode)
            opc_op_imm: begin
                ex_type = ex_alu;
                op_type = alu_op(func3, instr[30], 1'b0);
                use_rd  = 1'b1;
                use_imm = 1'b1;
                imm     = (func3 == 3'h1 || func3 == 3'h5) ? shamt_imm : i_imm;
                rd_r    = rd;
                rs1_r   = rs1;
            end
            opc_op: begin
                ex_type = ex_alu;
                op_type = alu_op(func3, instr[30], 1'b1);
                use_rd  = 1'b1;
                rd_r    = rd;
                rs1_r   = rs1;
                rs2_r   = rs2;
            end
            opc_lui, opc_auipc: begin
                ex_type = ex_alu;
                op_type = opcode[5] ? alu_lui : alu_auipc;
                use_rd  = 1'b1;
                use_imm = 1'b1;
                use_pc  = ~opcode[5];  // AUIPC adds to pc
                imm     = u_imm;
                rd_r    = rd;
            end
            opc_jal: begin
                ex_type   = ex_alu;
                op_type   = br_jal;
                op_mod    = mod_branch;
                use_rd    = 1'b1;
                use_imm   = 1'b1;
                use_pc    = 1'b1;
                is_wstall = 1'b1;
                imm       = j_imm;
                rd_r      = rd;
            end
            opc_jalr: begin
                ex_type   = ex_alu;
                op_type   = br_jalr;
                op_mod    = mod_branch;
                use_rd    = 1'b1;
                use_imm   = 1'b1;
                is_wstall = 1'b1;
                imm       = i_imm;
                rd_r      = rd;
                rs1_r     = rs1;
            end
            opc_branch: begin
                ex_type = ex_alu;
                case (func3)
                    3'h0:    op_type = br_eq;
                    3'h1:    op_type = br_ne;
                    3'h4:    op_type = br_lt;
                    3'h5:    op_type = br_ge;
                    3'h6:    op_type = br_ltu;
                    3'h7:    op_type = br_geu;
                    default: op_type = '0;
                endcase
                op_mod    = mod_branch;
                use_imm   = 1'b1;
                use_pc    = 1'b1;
                is_wstall = 1'b1;
                imm       = b_imm;
                rs1_r     = rs1;
                rs2_r     = rs2;
            end
            opc_load: begin
                ex_type = ex_lsu;
                op_type = {1'b0, func3};
                use_rd  = 1'b1;
                imm     = i_imm;
                rd_r    = rd;
                rs1_r   = rs1;
            end
            opc_store: begin
                ex_type = ex_lsu;
                op_type = {1'b1, func3};
                imm     = s_imm;
                rs1_r   = rs1;
                rs2_r   = rs2;
            end
            opc_fence: begin
                ex_type = ex_lsu;
                op_mod  = mod_fence;
            end
            opc_ext1: begin
                if (func7 == 7'h00) begin
                    case (func3)
                        3'h0: begin  // TMC or PRED, picked by rs2[0]
                            ex_type   = ex_gpu;
                            op_type   = rs2[0] ? gpu_pred : gpu_tmc;
                            is_wstall = 1'b1;
                            rs1_r     = rs1;
                        end
                        3'h1: begin
                            ex_type = ex_gpu;
                            op_type = gpu_wspawn;
                            rs1_r   = rs1;
                            rs2_r   = rs2;
                        end
                        3'h2: begin
                            ex_type   = ex_gpu;
                            op_type   = gpu_split;
                            is_wstall = 1'b1;
                            rs1_r     = rs1;
                        end
                        3'h3: begin
                            ex_type = ex_gpu;
                            op_type = gpu_join;
                            is_join = 1'b1;
                        end
                        3'h4: begin
                            ex_type   = ex_gpu;
                            op_type   = gpu_bar;
                            is_wstall = 1'b1;
                            rs1_r     = rs1;
                            rs2_r     = rs2;
                        end
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase
    end

    assign dec.uuid    = fetch.uuid;
    assign dec.wid     = fetch.wid;
    assign dec.tmask   = fetch.tmask;
    assign dec.pc      = fetch.pc;
    assign dec.ex_type = ex_type;
    assign dec.op_type = op_type;
    assign dec.op_mod  = op_mod;
    assign dec.wb      = use_rd && (|rd_r);  // No write to x0
    assign dec.rd      = rd_r;
    assign dec.rs1     = rs1_r;
    assign dec.rs2     = rs2_r;
    assign dec.imm     = imm;
    assign dec.use_pc  = use_pc;
    assign dec.use_imm = use_imm;

    // Stalling instructions release their warp later, in execute
    assign evt.wid        = fetch.wid;
    assign evt.is_join    = is_join;
    assign evt.is_release = ~is_wstall && ~is_join;
    assign evt_needed     = evt.is_join || evt.is_release;

endmodule

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

    localparam int nr_bits     = 5;
    localparam int op_mod_bits = 2;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_fence  = 7'b0001111;
    localparam logic [6:0] opc_ext1   = 7'b0001011;  // GPU warp control

    typedef enum logic [2:0] {
        ex_none = 3'd0,
        ex_alu  = 3'd1,
        ex_lsu  = 3'd2,
        ex_gpu  = 3'd3
    } ex_type_e;

    // Meaning depends on ex_type and op_mod, so values overlap
    typedef logic [3:0] op_type_e;

    localparam op_type_e alu_add   = 4'd0;
    localparam op_type_e alu_sub   = 4'd1;
    localparam op_type_e alu_sll   = 4'd2;
    localparam op_type_e alu_slt   = 4'd3;
    localparam op_type_e alu_sltu  = 4'd4;
    localparam op_type_e alu_xor   = 4'd5;
    localparam op_type_e alu_srl   = 4'd6;
    localparam op_type_e alu_sra   = 4'd7;
    localparam op_type_e alu_or    = 4'd8;
    localparam op_type_e alu_and   = 4'd9;
    localparam op_type_e alu_lui   = 4'd10;
    localparam op_type_e alu_auipc = 4'd11;

    localparam op_type_e br_eq   = 4'd0;
    localparam op_type_e br_ne   = 4'd1;
    localparam op_type_e br_lt   = 4'd4;
    localparam op_type_e br_ge   = 4'd5;
    localparam op_type_e br_ltu  = 4'd6;
    localparam op_type_e br_geu  = 4'd7;
    localparam op_type_e br_jal  = 4'd8;
    localparam op_type_e br_jalr = 4'd9;

    localparam op_type_e gpu_tmc    = 4'd0;
    localparam op_type_e gpu_wspawn = 4'd1;
    localparam op_type_e gpu_split  = 4'd2;
    localparam op_type_e gpu_join   = 4'd3;
    localparam op_type_e gpu_bar    = 4'd4;
    localparam op_type_e gpu_pred   = 4'd5;

    localparam logic [op_mod_bits-1:0] mod_branch = 2'd1;  // With ex_alu
    localparam logic [op_mod_bits-1:0] mod_fence  = 2'd1;  // With ex_lsu

    typedef struct packed {
        logic [core_cfg_pkg::uuid_bits-1:0]   uuid;
        logic [core_cfg_pkg::wid_bits-1:0]    wid;
        logic [core_cfg_pkg::num_threads-1:0] tmask;
        logic [core_cfg_pkg::xlen-1:0]        pc;
        ex_type_e                             ex_type;
        op_type_e                             op_type;
        logic [op_mod_bits-1:0]               op_mod;
        logic                                 wb;
        logic [nr_bits-1:0]                   rd;
        logic [nr_bits-1:0]                   rs1;
        logic [nr_bits-1:0]                   rs2;
        logic [core_cfg_pkg::xlen-1:0]        imm;
        logic                                 use_pc;
        logic                                 use_imm;
    } decoded_t;

endpackage

// ==== hdl/core_cfg_pkg.sv ====
package core_cfg_pkg;

    // Machine sizes
    localparam int xlen        = 32;
    localparam int num_warps   = 4;
    localparam int wid_bits    = $clog2(num_warps);
    localparam int num_threads = 4;
    localparam int uuid_bits   = 8;

    // One fetched instruction with its warp context
    typedef struct packed {
        logic [uuid_bits-1:0]   uuid;
        logic [wid_bits-1:0]    wid;
        logic [num_threads-1:0] tmask;
        logic [xlen-1:0]        pc;
        logic [31:0]            instr;
    } fetch_t;

    // Warp-control event toward the scheduler
    typedef struct packed {
        logic [wid_bits-1:0] wid;
        logic                is_join;
        logic                is_release;  // Warp may fetch again
    } warp_event_t;

endpackage
